/* logic/int_pipe_pkg.sv */
`default_nettype none

package int_pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;

    // ALU function select
    typedef enum logic [2:0]
    {
        ALU_ADD  = 3'b000,
        ALU_SUB  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_AND  = 3'b100,
        ALU_NOR  = 3'b101,
        ALU_OR   = 3'b110,
        ALU_XOR  = 3'b111
    } alu_op_e;

    typedef enum logic [1:0]
    {
        SFT_LUI = 2'b00,
        SFT_SLL = 2'b01,
        SFT_SRA = 2'b10,
        SFT_SRL = 2'b11
    } sft_op_e;

    typedef enum logic [1:0]
    {
        OUT_ALU   = 2'b00,
        OUT_SHIFT = 2'b01,
        OUT_MOVE  = 2'b10,
        OUT_NONE  = 2'b11
    } out_sel_e;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // SPECIAL funct field
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_MOVZ = 6'b001010;
    localparam logic [5:0] FN_MOVN = 6'b001011;
    localparam logic [5:0] FN_SYNC = 6'b001111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

endpackage

`default_nettype wire

/* logic/pipe_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dec_exec_if;
    import int_pipe_pkg::*;

    logic      valid;
    logic      ready;
    alu_op_e   alu_op;
    sft_op_e   sft_op;
    out_sel_e  out_sel;
    logic      srcb_imm;                // Operand B from immediate
    logic      sft_var;                 // Shift amount from rs
    logic      reg_write;
    logic      move_on_zero;
    logic      move_on_nonzero;
    logic      reserved;
    reg_addr_t dest;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm_ext;
    shamt_t    shamt;

    modport src (output valid, alu_op, sft_op, out_sel, srcb_imm, sft_var, reg_write,
                 move_on_zero, move_on_nonzero, reserved, dest, rs_val, rt_val, imm_ext,
                 shamt, input ready);
    modport dst (input valid, alu_op, sft_op, out_sel, srcb_imm, sft_var, reg_write,
                 move_on_zero, move_on_nonzero, reserved, dest, rs_val, rt_val, imm_ext,
                 shamt, output ready);
endinterface

interface exec_res_if;
    import int_pipe_pkg::*;

    logic      valid;
    logic      ready;
    word_t     alu_res;
    word_t     sft_res;
    word_t     move_val;
    logic      rt_zero;
    out_sel_e  out_sel;
    logic      reg_write;
    logic      move_on_zero;
    logic      move_on_nonzero;
    logic      reserved;
    reg_addr_t dest;

    modport src (output valid, alu_res, sft_res, move_val, rt_zero, out_sel, reg_write,
                 move_on_zero, move_on_nonzero, reserved, dest, input ready);
    modport dst (input valid, alu_res, sft_res, move_val, rt_zero, out_sel, reg_write,
                 move_on_zero, move_on_nonzero, reserved, dest, output ready);
endinterface

`default_nettype wire

/* logic/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  int_pipe_pkg::instr_t  instr,
    input  int_pipe_pkg::word_t   rs_data,
    input  int_pipe_pkg::word_t   rt_data,
    dec_exec_if.src               down
);
    import int_pipe_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [15:0] imm;
    alu_op_e    alu_op;
    sft_op_e    sft_op;
    out_sel_e   out_sel;
    logic       srcb_imm;
    logic       sft_var;
    logic       reg_write;
    logic       move_on_zero;
    logic       move_on_nonzero;
    logic       reserved;
    logic       imm_sign;
    logic       rd_dest;
    reg_addr_t  dest;
    word_t      imm_ext;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    always_comb
    begin
        // Defaults describe an immediate ALU op
        alu_op          = ALU_ADD;
        sft_op          = SFT_LUI;
        out_sel         = OUT_ALU;
        srcb_imm        = 1'b1;
        sft_var         = 1'b0;
        reg_write       = 1'b1;
        move_on_zero    = 1'b0;
        move_on_nonzero = 1'b0;
        reserved        = 1'b0;
        imm_sign        = 1'b0;
        rd_dest         = 1'b0;
        case (opcode)
            OP_SPECIAL:
            begin
                srcb_imm = 1'b0;
                rd_dest  = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD;   // No overflow trap
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_SLT:          alu_op = ALU_SLT;
                    FN_SLTU:         alu_op = ALU_SLTU;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_NOR:          alu_op = ALU_NOR;
                    FN_SLL, FN_SLLV:
                    begin
                        out_sel = OUT_SHIFT;
                        sft_op  = SFT_SLL;
                        sft_var = funct[2];      // Set for the V forms
                    end
                    FN_SRL, FN_SRLV:
                    begin
                        out_sel = OUT_SHIFT;
                        sft_op  = SFT_SRL;
                        sft_var = funct[2];
                    end
                    FN_SRA, FN_SRAV:
                    begin
                        out_sel = OUT_SHIFT;
                        sft_op  = SFT_SRA;
                        sft_var = funct[2];
                    end
                    FN_MOVZ:
                    begin
                        out_sel      = OUT_MOVE;
                        reg_write    = 1'b0;     // Resolved after execute
                        move_on_zero = 1'b1;
                    end
                    FN_MOVN:
                    begin
                        out_sel         = OUT_MOVE;
                        reg_write       = 1'b0;
                        move_on_nonzero = 1'b1;
                    end
                    FN_SYNC:
                    begin
                        out_sel   = OUT_NONE;
                        reg_write = 1'b0;
                    end
                    default:
                    begin
                        out_sel   = OUT_NONE;
                        reg_write = 1'b0;
                        reserved  = 1'b1;
                    end
                endcase
            end
            OP_ADDI, OP_ADDIU:
            begin
                alu_op   = ALU_ADD;
                imm_sign = 1'b1;
            end
            OP_SLTI:
            begin
                alu_op   = ALU_SLT;
                imm_sign = 1'b1;
            end
            OP_SLTIU:
            begin
                alu_op   = ALU_SLTU;
                imm_sign = 1'b1;
            end
            OP_ANDI: alu_op  = ALU_AND;
            OP_ORI:  alu_op  = ALU_OR;
            OP_XORI: alu_op  = ALU_XOR;
            OP_LUI:  out_sel = OUT_SHIFT;
            default:
            begin
                out_sel   = OUT_NONE;
                reg_write = 1'b0;
                reserved  = 1'b1;
            end
        endcase
    end

    assign dest    = rd_dest ? instr[15:11] : instr[20:16];
    assign imm_ext = imm_sign ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    assign in_ready = !down.valid || down.ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            down.valid <= 1'b0;
        else if (in_ready)
            down.valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            down.alu_op          <= alu_op;
            down.sft_op          <= sft_op;
            down.out_sel         <= out_sel;
            down.srcb_imm        <= srcb_imm;
            down.sft_var         <= sft_var;
            down.reg_write       <= reg_write;
            down.move_on_zero    <= move_on_zero;
            down.move_on_nonzero <= move_on_nonzero;
            down.reserved        <= reserved;
            down.dest            <= dest;
            down.rs_val          <= rs_data;
            down.rt_val          <= rt_data;
            down.imm_ext         <= imm_ext;
            down.shamt           <= instr[10:6];
        end
    end

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic       clk,
    input  logic       reset,
    dec_exec_if.dst    up,
    exec_res_if.src    down
);
    import int_pipe_pkg::*;

    word_t  srcb;
    word_t  alu_res;
    word_t  sft_res;
    shamt_t sft_amt;

    assign srcb    = up.srcb_imm ? up.imm_ext : up.rt_val;
    assign sft_amt = up.sft_var ? up.rs_val[4:0] : up.shamt;

    always_comb
    begin
        case (up.alu_op)
            ALU_ADD:  alu_res = up.rs_val + srcb;
            ALU_SUB:  alu_res = up.rs_val - srcb;
            ALU_SLT:  alu_res = {31'b0, $signed(up.rs_val) < $signed(srcb)};
            ALU_SLTU: alu_res = {31'b0, up.rs_val < srcb};
            ALU_AND:  alu_res = up.rs_val & srcb;
            ALU_NOR:  alu_res = ~(up.rs_val | srcb);
            ALU_OR:   alu_res = up.rs_val | srcb;
            ALU_XOR:  alu_res = up.rs_val ^ srcb;
            default:  alu_res = '0;
        endcase
    end

    always_comb
    begin
        case (up.sft_op)
            SFT_LUI: sft_res = {up.imm_ext[15:0], 16'h0000};
            SFT_SLL: sft_res = up.rt_val << sft_amt;
            SFT_SRA: sft_res = $signed(up.rt_val) >>> sft_amt;   // Sign fill
            SFT_SRL: sft_res = up.rt_val >> sft_amt;
            default: sft_res = '0;
        endcase
    end

    assign up.ready = !down.valid || down.ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            down.valid <= 1'b0;
        else if (up.ready)
            down.valid <= up.valid;
    end

    always_ff @(posedge clk)
    begin
        if (up.valid && up.ready)
        begin
            down.alu_res         <= alu_res;
            down.sft_res         <= sft_res;
            down.move_val        <= up.rs_val;
            down.rt_zero         <= (up.rt_val == '0);   // For MOVZ and MOVN
            down.out_sel         <= up.out_sel;
            down.reg_write       <= up.reg_write;
            down.move_on_zero    <= up.move_on_zero;
            down.move_on_nonzero <= up.move_on_nonzero;
            down.reserved        <= up.reserved;
            down.dest            <= up.dest;
        end
    end

    // A stalled record stays put until the writeback stage takes it
    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        down.valid && !down.ready |=> down.valid && $stable(down.alu_res));

endmodule

`default_nettype wire

/* logic/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic                     clk,
    input  logic                     reset,
    exec_res_if.dst                  up,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     out_wen,
    output int_pipe_pkg::reg_addr_t  out_dest,
    output int_pipe_pkg::word_t      out_data,
    output logic                     out_reserved
);
    import int_pipe_pkg::*;

    word_t     sel_data;
    reg_addr_t sel_dest;
    logic      sel_wen;

    always_comb
    begin
        case (up.out_sel)
            OUT_ALU:   sel_data = up.alu_res;
            OUT_SHIFT: sel_data = up.sft_res;
            OUT_MOVE:  sel_data = up.move_val;
            default:   sel_data = '0;          // SYNC and reserved
        endcase
    end

    assign sel_dest = (up.out_sel == OUT_NONE) ? '0 : up.dest;
    assign sel_wen  = up.reg_write
                   || (up.move_on_zero && up.rt_zero)
                   || (up.move_on_nonzero && !up.rt_zero);

    assign up.ready = !out_valid || out_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else if (up.ready)
            out_valid <= up.valid;
    end

    always_ff @(posedge clk)
    begin
        if (up.valid && up.ready)
        begin
            out_wen      <= sel_wen;
            out_dest     <= sel_dest;
            out_data     <= sel_data;
            out_reserved <= up.reserved;
        end
    end

    // Reserved encodings never write the register file
    a_reserved_no_write: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_reserved |-> !out_wen);

endmodule

`default_nettype wire

/* logic/int_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module int_pipe_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  int_pipe_pkg::instr_t     instr,
    input  int_pipe_pkg::word_t      rs_data,
    input  int_pipe_pkg::word_t      rt_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     out_wen,
    output int_pipe_pkg::reg_addr_t  out_dest,
    output int_pipe_pkg::word_t      out_data,
    output logic                     out_reserved
);

    dec_exec_if u_dec_exec_if ();
    exec_res_if u_exec_res_if ();

    instr_decoder u_instr_decoder (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .instr    (instr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .down     (u_dec_exec_if.src)
    );

    exec_unit u_exec_unit (
        .clk   (clk),
        .reset (reset),
        .up    (u_dec_exec_if.dst),
        .down  (u_exec_res_if.src)
    );

    result_stage u_result_stage (
        .clk          (clk),
        .reset        (reset),
        .up           (u_exec_res_if.dst),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_wen      (out_wen),
        .out_dest     (out_dest),
        .out_data     (out_data),
        .out_reserved (out_reserved)
    );

endmodule

`default_nettype wire

/* bench/int_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module int_pipe_tb;
    import int_pipe_pkg::*;

    typedef struct packed
    {
        logic      wen;
        reg_addr_t dest;
        word_t     data;
        logic      reserved;
    } expect_t;

    localparam int num_instr      = 400;
    localparam int timeout_cycles = 200;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    instr_t    instr;
    word_t     rs_data;
    word_t     rt_data;
    logic      out_valid;
    logic      out_ready;
    logic      out_wen;
    reg_addr_t out_dest;
    word_t     out_data;
    logic      out_reserved;

    expect_t     exp_q[$];
    logic [31:0] rng_state;
    logic        in_fire;
    logic        aborted;
    int          in_count;
    int          out_count;
    int          mismatch_count;
    int          other_errors;

    int_pipe_top u_int_pipe_top (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .instr        (instr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_wen      (out_wen),
        .out_dest     (out_dest),
        .out_data     (out_data),
        .out_reserved (out_reserved)
    );

    always #10 clk = ~clk;

    function logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic word_t less_signed(input word_t a, input word_t b);
        return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};   // Negative operand wins
    endfunction

    function automatic word_t shift_arith(input word_t v, input shamt_t n);
        return (v >> n) | (v[31] ? ~(32'hffff_ffff >> n) : 32'h0);
    endfunction

    function automatic expect_t ref_model(input instr_t ins, input word_t rs, input word_t rt);
        expect_t e;
        word_t   simm;
        word_t   zimm;
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0000, ins[15:0]};
        e = '{wen: 1'b1, dest: ins[20:16], data: '0, reserved: 1'b0};
        case (ins[31:26])
            OP_SPECIAL:
            begin
                e.dest = ins[15:11];
                case (ins[5:0])
                    FN_ADD, FN_ADDU: e.data = rs + rt;
                    FN_SUB, FN_SUBU: e.data = rs - rt;
                    FN_SLT:  e.data = less_signed(rs, rt);
                    FN_SLTU: e.data = {31'b0, rs < rt};
                    FN_AND:  e.data = rs & rt;
                    FN_OR:   e.data = rs | rt;
                    FN_XOR:  e.data = rs ^ rt;
                    FN_NOR:  e.data = ~(rs | rt);
                    FN_SLL:  e.data = rt << ins[10:6];
                    FN_SRL:  e.data = rt >> ins[10:6];
                    FN_SRA:  e.data = shift_arith(rt, ins[10:6]);
                    FN_SLLV: e.data = rt << rs[4:0];
                    FN_SRLV: e.data = rt >> rs[4:0];
                    FN_SRAV: e.data = shift_arith(rt, rs[4:0]);
                    FN_MOVZ, FN_MOVN:
                    begin
                        e.data = rs;
                        e.wen  = (rt == 32'h0) ^ ins[0];   // MOVN has funct bit 0 set
                    end
                    FN_SYNC: e = '{wen: 1'b0, dest: '0, data: '0, reserved: 1'b0};
                    default: e = '{wen: 1'b0, dest: '0, data: '0, reserved: 1'b1};
                endcase
            end
            OP_ADDI, OP_ADDIU: e.data = rs + simm;
            OP_SLTI:  e.data = less_signed(rs, simm);
            OP_SLTIU: e.data = {31'b0, rs < simm};
            OP_ANDI:  e.data = rs & zimm;
            OP_ORI:   e.data = rs | zimm;
            OP_XORI:  e.data = rs ^ zimm;
            OP_LUI:   e.data = {ins[15:0], 16'h0000};
            default:  e = '{wen: 1'b0, dest: '0, data: '0, reserved: 1'b1};
        endcase
        return e;
    endfunction

    task automatic drive_random_instr();
        logic [31:0] r;
        logic [31:0] w;
        word_t       b;
        r = next_rand();
        w = next_rand();
        b = next_rand();
        case (r[30:28])
            3'd0: w = {OP_SPECIAL, w[25:6], 3'b100, r[26:24]};   // ADD through NOR
            3'd1: w = {OP_SPECIAL, w[25:6], 5'b10101, r[24]};    // SLT, SLTU
            3'd2: w = {3'b001, r[26:24], w[25:0]};               // Immediate forms and LUI
            3'd3: w = {OP_SPECIAL, w[25:6], 3'b000, r[26:24]};   // Shifts
            3'd4:
            begin
                w = {OP_SPECIAL, w[25:6], 5'b00101, r[24]};      // MOVZ, MOVN
                if (r[23])
                    b = '0;
            end
            3'd5: w = {OP_SPECIAL, w[25:6], FN_SYNC};
            3'd6: w = {OP_SPECIAL, w[25:0]};
            default: ;                                           // Mostly reserved opcodes
        endcase
        instr   <= w;
        rs_data <= next_rand();
        rt_data <= b;
    endtask

    // Handshakes sampled mid-cycle before the transfer edge
    always @(negedge clk)
    begin
        in_fire = !reset && in_valid && (in_ready === 1'b1);
        if (in_fire)
        begin
            exp_q.push_back(ref_model(instr, rs_data, rt_data));
            in_count++;
        end
    end

    always @(negedge clk)
    begin
        expect_t e;
        if (!reset && out_valid === 1'b1 && out_ready)
        begin
            out_count++;
            if (exp_q.size() == 0)
            begin
                other_errors++;
                $display("Output record at %0t arrived with no input waiting for it", $time);
            end
            else
            begin
                e = exp_q.pop_front();
                assert (out_wen === e.wen)
                else begin
                    mismatch_count++;
                    $display("MISMATCH %0t: out_wen %b expected %b", $time, out_wen, e.wen);
                end
                assert (out_dest === e.dest)
                else begin
                    mismatch_count++;
                    $display("MISMATCH %0t: out_dest %0d expected %0d", $time, out_dest, e.dest);
                end
                assert (out_data === e.data)
                else begin
                    mismatch_count++;
                    $display("MISMATCH %0t: out_data %h expected %h", $time, out_data, e.data);
                end
                assert (out_reserved === e.reserved)
                else begin
                    mismatch_count++;
                    $display("MISMATCH %0t: out_reserved %b expected %b", $time, out_reserved,
                             e.reserved);
                end
            end
        end
    end

    task automatic check_latency();
        int   waited;
        int   edges;
        logic seen;
        @(posedge clk);
        out_ready <= 1'b1;
        instr     <= {OP_ADDIU, 5'd3, 5'd7, 16'h8001};
        rs_data   <= 32'h0000_1000;
        rt_data   <= 32'h0;
        in_valid  <= 1'b1;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
        end
        while (!in_fire && waited < timeout_cycles);
        in_valid <= 1'b0;
        if (!in_fire)
        begin
            other_errors++;
            aborted = 1'b1;
            $display("Timeout: the pipeline never accepted the first instruction");
        end
        else
        begin
            edges = 0;
            do
            begin
                @(negedge clk);
                seen = out_valid;                        // Taken at the next edge
                @(posedge clk);
                edges++;
            end
            while (seen !== 1'b1 && edges < timeout_cycles);
            assert (edges == 3)
            else begin
                mismatch_count++;
                $display("MISMATCH %0t: latency %0d edges expected 3", $time, edges);
            end
        end
    endtask

    task automatic run_random_traffic();
        int sent;
        int waited;
        logic [31:0] r;
        sent = 0;
        waited = 0;
        while (sent < num_instr && !aborted)
        begin
            @(posedge clk);
            r = next_rand();
            out_ready <= (r[31:30] != 2'b00);
            if (in_valid && !in_fire)
            begin
                waited++;                                // Held until accepted
                if (waited > timeout_cycles)
                begin
                    other_errors++;
                    aborted = 1'b1;
                    $display("Timeout: input stalled at %0t after %0d instructions", $time, sent);
                end
            end
            else
            begin
                waited = 0;
                if (in_fire)
                    sent++;
                if (sent < num_instr && r[29:28] != 2'b00)
                begin
                    drive_random_instr();
                    in_valid <= 1'b1;
                end
                else
                    in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drain_outputs();
        int waited;
        out_ready <= 1'b1;
        waited = 0;
        while (exp_q.size() != 0 && waited < timeout_cycles)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            other_errors++;
            $display("Timeout: %0d expected outputs went missing", exp_q.size());
        end
        repeat (5) @(posedge clk);                       // Catch any extra records
    endtask

    initial
    begin
        clk            = 1'b0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        instr          = '0;
        rs_data        = '0;
        rt_data        = '0;
        out_ready      = 1'b0;
        in_fire        = 1'b0;
        aborted        = 1'b0;
        rng_state      = 32'h90f6229d;
        in_count       = 0;
        out_count      = 0;
        mismatch_count = 0;
        other_errors   = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        check_latency();
        run_random_traffic();
        drain_outputs();
        assert (out_count == in_count)
        else begin
            mismatch_count++;
            $display("MISMATCH %0t: %0d outputs for %0d inputs", $time, out_count, in_count);
        end
        $display("Errors: %0d mismatches, %0d other failures (%0d in, %0d out)",
                 mismatch_count, other_errors, in_count, out_count);
        if (mismatch_count == 0 && other_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/int_pipe_pkg.sv
logic/pipe_if.sv
logic/instr_decoder.sv
logic/exec_unit.sv
logic/result_stage.sv
logic/int_pipe_top.sv
bench/int_pipe_tb.sv

/* Bender.yml */
package:
  name: int_pipe

sources:
  - files:
      - logic/int_pipe_pkg.sv
      - logic/pipe_if.sv
      - logic/instr_decoder.sv
      - logic/exec_unit.sv
      - logic/result_stage.sv
      - logic/int_pipe_top.sv
  - target: test
    files:
      - bench/int_pipe_tb.sv
